/* rtl/axil_cfg.svh */
`ifndef AXIL_CFG_SVH
`define AXIL_CFG_SVH

// bus widths shared by packages and routers
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// top address bits that pick the slave
`define AXIL_SEL_W 2

`define AXIL_STRB_W (`AXIL_DATA_W / 8)

`endif

/* rtl/axil_bus_pkg.sv */
`include "axil_cfg.svh"

package axil_bus_pkg;

    typedef logic [`AXIL_ADDR_W-1:0] addr_t;
    typedef logic [`AXIL_DATA_W-1:0] data_t;
    typedef logic [`AXIL_STRB_W-1:0] strb_t;

    // one complete write as seen by the arbiter, aw and w together
    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
    } wr_req_t;

endpackage

/* rtl/axil_map_pkg.sv */
`include "axil_cfg.svh"

package axil_map_pkg;

    localparam int SLAVE_COUNT = 1 << `AXIL_SEL_W;

    typedef logic [`AXIL_SEL_W-1:0] slave_idx_t;

    // m0 has priority over m1 on both paths
    typedef enum logic {
        MST_M0 = 1'b0,
        MST_M1 = 1'b1
    } master_id_t;

endpackage

/* rtl/master_priority_select.sv */
`timescale 1ns/1ns

module master_priority_select import axil_bus_pkg::*, axil_map_pkg::*; #(
    parameter type payload_t = addr_t
) (
    input  payload_t   req_a,
    input  logic       valid_a,
    input  payload_t   req_b,
    input  logic       valid_b,
    output payload_t   req,
    output logic       valid,
    output master_id_t grant
);

    always_comb begin
        if (valid_a) begin
            grant = MST_M0;  // side a always wins
            req   = req_a;
        end else begin
            grant = MST_M1;
            req   = req_b;
        end
        valid = valid_a | valid_b;
    end

endmodule

/* rtl/axil_write_router.sv */
`timescale 1ns/1ns
`include "axil_cfg.svh"

module axil_write_router import axil_bus_pkg::*, axil_map_pkg::*; (
    input  addr_t   m_awaddr  [2],
    input  logic    m_awvalid [2],
    input  data_t   m_wdata   [2],
    input  strb_t   m_wstrb   [2],
    input  logic    m_wvalid  [2],
    output logic    m_awready [2],
    output logic    m_wready  [2],
    output addr_t   s_awaddr  [SLAVE_COUNT],
    output logic    s_awvalid [SLAVE_COUNT],
    input  logic    s_awready [SLAVE_COUNT],
    output data_t   s_wdata   [SLAVE_COUNT],
    output strb_t   s_wstrb   [SLAVE_COUNT],
    output logic    s_wvalid  [SLAVE_COUNT],
    input  logic    s_wready  [SLAVE_COUNT]
);

    wr_req_t    m_req [2];
    logic       m_vld [2];
    wr_req_t    win_req;
    logic       win_valid;
    master_id_t win_grant;
    slave_idx_t dec;

    // a master only competes once both aw and w are presented
    always_comb begin
        for (int m = 0; m < 2; m++) begin
            m_req[m] = '{addr: m_awaddr[m], data: m_wdata[m], strb: m_wstrb[m]};
            m_vld[m] = m_awvalid[m] & m_wvalid[m];
        end
    end

    master_priority_select #(
        .payload_t (wr_req_t)
    ) wr_sel_i (
        .req_a   (m_req[0]),
        .valid_a (m_vld[0]),
        .req_b   (m_req[1]),
        .valid_b (m_vld[1]),
        .req     (win_req),
        .valid   (win_valid),
        .grant   (win_grant)
    );

    assign dec = win_req.addr[`AXIL_ADDR_W-1 -: `AXIL_SEL_W];

    always_comb begin
        for (int s = 0; s < SLAVE_COUNT; s++) begin
            s_awvalid[s] = win_valid && (dec == slave_idx_t'(s)) && m_awvalid[win_grant];
            s_wvalid[s]  = win_valid && (dec == slave_idx_t'(s)) && m_wvalid[win_grant];
            s_awaddr[s]  = (dec == slave_idx_t'(s)) ? win_req.addr : '0;
            s_wdata[s]   = win_req.data;  // broadcast, qualified by wvalid
            s_wstrb[s]   = win_req.strb;
        end
    end

    // ready goes back to the granted master only
    always_comb begin
        for (int m = 0; m < 2; m++) begin
            m_awready[m] = win_valid && (win_grant == master_id_t'(m)) && s_awready[dec];
            m_wready[m]  = win_valid && (win_grant == master_id_t'(m)) && s_wready[dec];
        end
    end

endmodule

/* rtl/axil_read_router.sv */
`timescale 1ns/1ns
`include "axil_cfg.svh"

module axil_read_router import axil_bus_pkg::*, axil_map_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  addr_t   m_araddr  [2],
    input  logic    m_arvalid [2],
    output logic    m_arready [2],
    output data_t   m_rdata   [2],
    output logic    m_rvalid  [2],
    input  logic    m_rready  [2],
    output addr_t   s_araddr  [SLAVE_COUNT],
    output logic    s_arvalid [SLAVE_COUNT],
    input  logic    s_arready [SLAVE_COUNT],
    input  data_t   s_rdata   [SLAVE_COUNT],
    input  logic    s_rvalid  [SLAVE_COUNT],
    output logic    s_rready  [SLAVE_COUNT]
);

    addr_t      win_addr;
    logic       win_valid;
    master_id_t win_grant;
    slave_idx_t dec;
    logic       ar_valid;
    logic       ar_fire;
    logic       r_fire;
    logic       busy;      // one read in flight
    slave_idx_t rd_idx;    // slave that owes the data
    master_id_t rd_owner;  // master that gets it

    master_priority_select #(
        .payload_t (addr_t)
    ) rd_sel_i (
        .req_a   (m_araddr[0]),
        .valid_a (m_arvalid[0]),
        .req_b   (m_araddr[1]),
        .valid_b (m_arvalid[1]),
        .req     (win_addr),
        .valid   (win_valid),
        .grant   (win_grant)
    );

    assign dec      = win_addr[`AXIL_ADDR_W-1 -: `AXIL_SEL_W];
    assign ar_valid = win_valid & ~busy;  // no new address while a read is open
    assign ar_fire  = ar_valid & s_arready[dec];
    assign r_fire   = busy & s_rvalid[rd_idx] & m_rready[rd_owner];

    always_comb begin
        for (int s = 0; s < SLAVE_COUNT; s++) begin
            s_arvalid[s] = ar_valid && (dec == slave_idx_t'(s));
            s_araddr[s]  = (dec == slave_idx_t'(s)) ? win_addr : '0;
            s_rready[s]  = busy && (rd_idx == slave_idx_t'(s)) && m_rready[rd_owner];
        end
    end

    always_comb begin
        for (int m = 0; m < 2; m++) begin
            m_arready[m] = ar_valid && (win_grant == master_id_t'(m)) && s_arready[dec];
            m_rvalid[m]  = busy && (rd_owner == master_id_t'(m)) && s_rvalid[rd_idx];
            m_rdata[m]   = s_rdata[rd_idx];  // both see data, only owner sees valid
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            rd_idx   <= '0;
            rd_owner <= MST_M0;
        end else if (ar_fire) begin
            busy     <= 1'b1;
            rd_idx   <= dec;
            rd_owner <= win_grant;
        end else if (r_fire) begin
            busy     <= 1'b0;  // next read accepted from the following cycle
        end
    end

endmodule

/* rtl/axil_2m_interconnect.sv */
`timescale 1ns/1ns

module axil_2m_interconnect import axil_bus_pkg::*, axil_map_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // master 0
    input  addr_t m0_awaddr,
    input  logic  m0_awvalid,
    output logic  m0_awready,
    input  data_t m0_wdata,
    input  strb_t m0_wstrb,
    input  logic  m0_wvalid,
    output logic  m0_wready,
    input  addr_t m0_araddr,
    input  logic  m0_arvalid,
    output logic  m0_arready,
    output data_t m0_rdata,
    output logic  m0_rvalid,
    input  logic  m0_rready,
    // master 1
    input  addr_t m1_awaddr,
    input  logic  m1_awvalid,
    output logic  m1_awready,
    input  data_t m1_wdata,
    input  strb_t m1_wstrb,
    input  logic  m1_wvalid,
    output logic  m1_wready,
    input  addr_t m1_araddr,
    input  logic  m1_arvalid,
    output logic  m1_arready,
    output data_t m1_rdata,
    output logic  m1_rvalid,
    input  logic  m1_rready,
    // slaves
    output addr_t s_awaddr  [SLAVE_COUNT],
    output logic  s_awvalid [SLAVE_COUNT],
    input  logic  s_awready [SLAVE_COUNT],
    output data_t s_wdata   [SLAVE_COUNT],
    output strb_t s_wstrb   [SLAVE_COUNT],
    output logic  s_wvalid  [SLAVE_COUNT],
    input  logic  s_wready  [SLAVE_COUNT],
    output addr_t s_araddr  [SLAVE_COUNT],
    output logic  s_arvalid [SLAVE_COUNT],
    input  logic  s_arready [SLAVE_COUNT],
    input  data_t s_rdata   [SLAVE_COUNT],
    input  logic  s_rvalid  [SLAVE_COUNT],
    output logic  s_rready  [SLAVE_COUNT]
);

    addr_t m_awaddr  [2];
    logic  m_awvalid [2];
    logic  m_awready [2];
    data_t m_wdata   [2];
    strb_t m_wstrb   [2];
    logic  m_wvalid  [2];
    logic  m_wready  [2];
    addr_t m_araddr  [2];
    logic  m_arvalid [2];
    logic  m_arready [2];
    data_t m_rdata   [2];
    logic  m_rvalid  [2];
    logic  m_rready  [2];

    // entry 0 is m0, the higher priority master
    assign m_awaddr  = '{m0_awaddr, m1_awaddr};
    assign m_awvalid = '{m0_awvalid, m1_awvalid};
    assign m_wdata   = '{m0_wdata, m1_wdata};
    assign m_wstrb   = '{m0_wstrb, m1_wstrb};
    assign m_wvalid  = '{m0_wvalid, m1_wvalid};
    assign m_araddr  = '{m0_araddr, m1_araddr};
    assign m_arvalid = '{m0_arvalid, m1_arvalid};
    assign m_rready  = '{m0_rready, m1_rready};

    assign m0_awready = m_awready[0];
    assign m1_awready = m_awready[1];
    assign m0_wready  = m_wready[0];
    assign m1_wready  = m_wready[1];
    assign m0_arready = m_arready[0];
    assign m1_arready = m_arready[1];
    assign m0_rdata   = m_rdata[0];
    assign m1_rdata   = m_rdata[1];
    assign m0_rvalid  = m_rvalid[0];
    assign m1_rvalid  = m_rvalid[1];

    axil_write_router wr_router_i (
        .m_awaddr  (m_awaddr),
        .m_awvalid (m_awvalid),
        .m_wdata   (m_wdata),
        .m_wstrb   (m_wstrb),
        .m_wvalid  (m_wvalid),
        .m_awready (m_awready),
        .m_wready  (m_wready),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready)
    );

    axil_read_router rd_router_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .m_araddr  (m_araddr),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_rdata   (m_rdata),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

endmodule

/* verification/tb_axil_interconnect.sv */
`timescale 1ns/1ns
`include "axil_cfg.svh"

module tb_axil_interconnect import axil_bus_pkg::*, axil_map_pkg::*; ();

    localparam int MAX_CYCLES = 200 * 20;  // 200 transactions, 20 cycles each

    logic  clk;
    logic  rst_n;
    addr_t m0_awaddr, m1_awaddr, m0_araddr, m1_araddr;
    data_t m0_wdata, m1_wdata, m0_rdata, m1_rdata;
    strb_t m0_wstrb, m1_wstrb;
    logic  m0_awvalid, m0_awready, m0_wvalid, m0_wready, m0_arvalid, m0_arready;
    logic  m1_awvalid, m1_awready, m1_wvalid, m1_wready, m1_arvalid, m1_arready;
    logic  m0_rvalid, m0_rready, m1_rvalid, m1_rready;
    addr_t s_awaddr [SLAVE_COUNT], s_araddr [SLAVE_COUNT];
    data_t s_wdata [SLAVE_COUNT], s_rdata [SLAVE_COUNT];
    strb_t s_wstrb [SLAVE_COUNT];
    logic  s_awvalid [SLAVE_COUNT], s_awready [SLAVE_COUNT], s_wvalid [SLAVE_COUNT];
    logic  s_wready [SLAVE_COUNT], s_arvalid [SLAVE_COUNT], s_arready [SLAVE_COUNT];
    logic  s_rvalid [SLAVE_COUNT], s_rready [SLAVE_COUNT];

    addr_t   wr_addr [2], rd_addr [2];  // master side, index 0 is m0
    data_t   wr_data [2];
    strb_t   wr_strb [2];
    logic    wr_vld [2], rd_vld [2], rd_rdy [2];
    data_t   smem [SLAVE_COUNT][64];     // slave model storage
    data_t   ref_mem [SLAVE_COUNT][64];  // expected contents
    wr_req_t exp_wr [SLAVE_COUNT][$];
    addr_t   wr_log [$];
    data_t   rd_buf [SLAVE_COUNT];
    logic    rd_pend [SLAVE_COUNT];
    int      rd_wait [SLAVE_COUNT];
    int      ref_wr_cnt [SLAVE_COUNT], obs_wr_cnt [SLAVE_COUNT], rd_issued [2], rd_seen [2];
    logic    busy_tb = 1'b0;  // a read is in flight
    int      owner_tb;
    logic [31:0] rng = 32'h98a1_45b4;
    int      err_val, err_misc, cyc;

    wire [1:0] wr_ack = {m1_awready & m1_wready, m0_awready & m0_wready};
    wire [1:0] ar_ack = {m1_arready, m0_arready};
    wire [1:0] r_vld  = {m1_rvalid, m0_rvalid};

    assign m0_awaddr  = wr_addr[0];
    assign m0_awvalid = wr_vld[0];
    assign m0_wdata   = wr_data[0];
    assign m0_wstrb   = wr_strb[0];
    assign m0_wvalid  = wr_vld[0];  // aw and w always presented together
    assign m0_araddr  = rd_addr[0];
    assign m0_arvalid = rd_vld[0];
    assign m0_rready  = rd_rdy[0];
    assign m1_awaddr  = wr_addr[1];
    assign m1_awvalid = wr_vld[1];
    assign m1_wdata   = wr_data[1];
    assign m1_wstrb   = wr_strb[1];
    assign m1_wvalid  = wr_vld[1];
    assign m1_araddr  = rd_addr[1];
    assign m1_arvalid = rd_vld[1];
    assign m1_rready  = rd_rdy[1];

    axil_2m_interconnect dut_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // expected slave for an address, top bits pick it
    function automatic slave_idx_t ref_slave(input addr_t a);
        return a[`AXIL_ADDR_W-1 -: `AXIL_SEL_W];
    endfunction

    function automatic data_t ref_merge(input data_t old, input data_t d, input strb_t s);
        data_t mask;
        for (int b = 0; b < `AXIL_STRB_W; b++)
            mask[8*b +: 8] = {8{s[b]}};
        return (old & ~mask) | (d & mask);
    endfunction

    function automatic addr_t make_addr(input int s, input int w);
        return (addr_t'(s) << (`AXIL_ADDR_W - `AXIL_SEL_W)) | (addr_t'(w) << 2);
    endfunction

    function automatic data_t fill_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %0t %s expected %h actual %h", $time, sig, exp, act);
        err_val++;
    endtask

    task automatic report_fault(input string msg);
        $display("%0t: %s", $time, msg);
        err_misc++;
    endtask

    task automatic write_txn(input int m, input addr_t a, input data_t d, input strb_t s);
        slave_idx_t t;
        t = ref_slave(a);
        exp_wr[t].push_back('{addr: a, data: d, strb: s});
        ref_mem[t][a[7:2]] = ref_merge(ref_mem[t][a[7:2]], d, s);
        ref_wr_cnt[t]++;
        @(negedge clk);
        wr_addr[m] = a;
        wr_data[m] = d;
        wr_strb[m] = s;
        wr_vld[m]  = 1'b1;
        #1;
        while (!wr_ack[m]) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        wr_vld[m] = 1'b0;
    endtask

    task automatic read_txn(input int m, input addr_t a);
        data_t exp;
        data_t got;
        exp = ref_mem[ref_slave(a)][a[7:2]];
        rd_issued[m]++;
        @(negedge clk);
        rd_addr[m] = a;
        rd_vld[m]  = 1'b1;
        #1;
        while (!ar_ack[m]) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        rd_vld[m] = 1'b0;
        rd_rdy[m] = (next_rand() % 3) != 0;  // random stall
        #1;
        while (!(r_vld[m] && rd_rdy[m])) begin
            @(negedge clk);
            rd_rdy[m] = (next_rand() % 3) != 0;
            #1;
        end
        got = m ? m1_rdata : m0_rdata;
        assert (got == exp) else value_error(m ? "m1_rdata" : "m0_rdata", exp, got);
        @(negedge clk);
        rd_rdy[m] = 1'b0;
    endtask

    task automatic observe_write(input int s);
        wr_req_t e;
        assert (s_wvalid[s] && s_wready[s])
            else report_fault($sformatf("slave %0d took an address without data", s));
        for (int o = 0; o < SLAVE_COUNT; o++)
            assert (o == s || (!s_awvalid[o] && !s_wvalid[o] && s_awaddr[o] == '0))
                else report_fault($sformatf("slave %0d saw a write meant for slave %0d", o, s));
        for (int b = 0; b < `AXIL_STRB_W; b++)
            if (s_wstrb[s][b])
                smem[s][s_awaddr[s][7:2]][8*b +: 8] = s_wdata[s][8*b +: 8];
        obs_wr_cnt[s]++;
        wr_log.push_back(s_awaddr[s]);
        if (exp_wr[s].size() == 0) begin
            report_fault($sformatf("unexpected write on slave %0d", s));
        end else begin
            e = exp_wr[s].pop_front();
            assert (s_awaddr[s] == e.addr)
                else value_error($sformatf("s_awaddr[%0d]", s), e.addr, s_awaddr[s]);
            assert (s_wdata[s] == e.data)
                else value_error($sformatf("s_wdata[%0d]", s), e.data, s_wdata[s]);
            assert (s_wstrb[s] == e.strb)
                else value_error($sformatf("s_wstrb[%0d]", s), e.strb, s_wstrb[s]);
        end
    endtask

    // slave models, aw and w accepted together
    always @(negedge clk) begin
        for (int s = 0; s < SLAVE_COUNT; s++) begin
            s_awready[s] = rst_n && (next_rand() % 4 != 0);
            s_wready[s]  = s_awready[s];
            s_arready[s] = rst_n && !rd_pend[s] && (next_rand() % 2 != 0);
            if (rd_pend[s] && rd_wait[s] > 0)
                rd_wait[s]--;
            s_rvalid[s] = rd_pend[s] && rd_wait[s] == 0;
            s_rdata[s]  = rd_buf[s];
        end
    end

    // sample just before the rising edge, where every signal is settled
    always @(negedge clk) begin
        logic [1:0] own;
        #1;
        if (rst_n) begin
            for (int s = 0; s < SLAVE_COUNT; s++) begin
                if (s_awvalid[s] && s_awready[s])
                    observe_write(s);
                if (s_arvalid[s] && s_arready[s]) begin
                    for (int o = 0; o < SLAVE_COUNT; o++)
                        assert (o == s || (!s_arvalid[o] && s_araddr[o] == '0))
                            else report_fault($sformatf("slave %0d saw a read meant for slave %0d",
                                                        o, s));
                    rd_pend[s] = 1'b1;
                    rd_buf[s]  = smem[s][s_araddr[s][7:2]];
                    rd_wait[s] = next_rand() % 4;  // random read latency
                end
                if (s_rvalid[s] && s_rready[s])
                    rd_pend[s] = 1'b0;
            end
            assert (!(m0_awvalid && m0_wvalid && (m1_awready || m1_wready)))
                else report_fault("m1 got write ready while m0 was requesting");
            assert (!busy_tb || !(m0_arready || m1_arready))
                else report_fault("arready high while a read was outstanding");
            own = busy_tb ? (2'b01 << owner_tb) : 2'b00;
            assert ((r_vld & ~own) == 2'b00)
                else report_fault("rvalid reached a master that owns no read");
            if (busy_tb && r_vld[owner_tb] && rd_rdy[owner_tb]) begin
                busy_tb = 1'b0;
                rd_seen[owner_tb]++;
            end else if (!busy_tb && ((ar_ack[0] && rd_vld[0]) || (ar_ack[1] && rd_vld[1]))) begin
                busy_tb  = 1'b1;
                owner_tb = (ar_ack[0] && rd_vld[0]) ? 0 : 1;
            end
        end
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d value, %0d other", err_val, err_misc);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int    m;
        addr_t a;
        clk   = 1'b0;
        rst_n = 1'b0;
        for (int i = 0; i < 2; i++) begin
            wr_addr[i] = '0;
            wr_data[i] = '0;
            wr_strb[i] = '0;
            wr_vld[i]  = 1'b0;
            rd_addr[i] = '0;
            rd_vld[i]  = 1'b0;
            rd_rdy[i]  = 1'b1;  // masters ready for data from reset on
        end
        for (int s = 0; s < SLAVE_COUNT; s++) begin
            s_awready[s] = 1'b0;
            s_wready[s]  = 1'b0;
            s_arready[s] = 1'b0;
            s_rvalid[s]  = 1'b0;
            s_rdata[s]   = '0;
            rd_pend[s]   = 1'b0;
            rd_wait[s]   = 0;
            rd_buf[s]    = '0;
            for (int w = 0; w < 64; w++) begin
                smem[s][w]    = fill_word(make_addr(s, w));
                ref_mem[s][w] = fill_word(make_addr(s, w));
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        for (int s = 0; s < SLAVE_COUNT; s++)
            assert (!s_awvalid[s] && !s_wvalid[s] && !s_arvalid[s] && !s_rready[s])
                else report_fault($sformatf("slave %0d valid or rready high after reset", s));
        assert (!m0_rvalid && !m1_rvalid) else report_fault("rvalid high after reset");

        for (int s = 0; s < SLAVE_COUNT; s++) begin
            write_txn(0, make_addr(s, s + 1), next_rand(), 4'hf);
            write_txn(1, make_addr(s, s + 9), next_rand(), 4'b0101);
        end

        wr_log.delete();
        fork
            write_txn(0, make_addr(2, 5), 32'h1111_2222, 4'hf);
            write_txn(1, make_addr(1, 7), 32'h3333_4444, 4'hf);
        join
        assert (wr_log.size() == 2 && wr_log[0] == make_addr(2, 5))
            else report_fault("m0 did not win the simultaneous write");

        fork
            read_txn(0, make_addr(2, 5));
            read_txn(1, make_addr(3, 10));  // waits out m0's read
        join

        for (int n = 0; n < 160; n++) begin
            m = next_rand() % 2;
            a = make_addr(next_rand() % SLAVE_COUNT, next_rand() % 8);
            if (next_rand() % 2 != 0)
                write_txn(m, a, next_rand(), strb_t'(next_rand()));
            else
                read_txn(m, a);
        end

        repeat (4) @(negedge clk);
        for (int s = 0; s < SLAVE_COUNT; s++)
            assert (obs_wr_cnt[s] == ref_wr_cnt[s] && exp_wr[s].size() == 0)
                else report_fault($sformatf("slave %0d took %0d writes, %0d were sent",
                                            s, obs_wr_cnt[s], ref_wr_cnt[s]));
        for (int i = 0; i < 2; i++)
            assert (rd_seen[i] == rd_issued[i])
                else report_fault($sformatf("m%0d got %0d reads back, %0d were sent",
                                            i, rd_seen[i], rd_issued[i]));
        $display("errors: %0d value, %0d other", err_val, err_misc);
        if (err_val + err_misc == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* build.f */
+incdir+rtl
rtl/axil_bus_pkg.sv
rtl/axil_map_pkg.sv
rtl/master_priority_select.sv
rtl/axil_write_router.sv
rtl/axil_read_router.sv
rtl/axil_2m_interconnect.sv
verification/tb_axil_interconnect.sv

/* Bender.yml */
package:
  name: axil_2m_interconnect

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axil_bus_pkg.sv
      - rtl/axil_map_pkg.sv
      - rtl/master_priority_select.sv
      - rtl/axil_write_router.sv
      - rtl/axil_read_router.sv
      - rtl/axil_2m_interconnect.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/tb_axil_interconnect.sv
